// File: vlog.f
verilog/mips_pkg.sv
verilog/test_program_rom.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_writeback_stage.sv
verilog/mips_cpu_top.sv
sim/mips_cpu_tb.sv

// File: run.sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module mips_cpu_tb \
    -Mdir obj_dir -o mips_cpu_sim -f vlog.f || { echo "build failed"; exit 1; }
./obj_dir/mips_cpu_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// File: sim/mips_cpu_tb.sv
`timescale 1ns/1ps

module mips_cpu_tb;

    // mirrors the top parameters of the core
    localparam int unsigned series_count = 30;
    localparam int unsigned store_base   = 32'h480;
    localparam int unsigned mem_words    = 512;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            active;
    mips_pkg::word_t data_address;
    logic            data_read;
    logic            data_write;
    mips_pkg::word_t data_writedata;
    mips_pkg::word_t data_readdata;

    // data memory model, word indexed
    mips_pkg::word_t mem [0:mem_words-1];

    // series parameters drawn at start
    integer          seed;
    mips_pkg::word_t seed_value;
    mips_pkg::word_t step;

    // strobes seen since the last reset
    int read_count;
    int write_count;

    mips_cpu_top #(
        .series_count (series_count),
        .store_base   (store_base)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .data_address   (data_address),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #5 clk = ~clk;

    // memory answers in the same cycle
    assign data_readdata = mem[data_address[10:2]];

    // value a store of series element k must carry
    // series(k) plus the sign-extended low half of 0x1111*k
    function automatic mips_pkg::word_t expected_store(input int k);
        logic [31:0] product;
        logic [15:0] low_half;
        product  = 32'h1111 * 32'(k);
        low_half = product[15:0];
        return seed_value + step * 32'(k) + {{16{low_half[15]}}, low_half};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // bus monitor, samples mid-cycle where the strobes are settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("read and write strobes overlap", 1'b0, data_read && data_write);
            // an idle core keeps the bus quiet
            if (!active) begin
                check_bit("read strobe while idle", 1'b0, data_read);
                check_bit("write strobe while idle", 1'b0, data_write);
            end
            if (data_read) begin
                if (read_count >= int'(series_count)) begin
                    abort_run("more data reads than the program issues");
                end
                // loads walk the series upwards from address 0
                check_word($sformatf("read %0d address", read_count),
                           32'(4 * read_count), data_address);
                read_count++;
            end
            if (data_write) begin
                if (write_count >= int'(series_count)) begin
                    abort_run("more data writes than the program issues");
                end
                check_word($sformatf("write %0d address", write_count),
                           store_base + 32'(4 * write_count), data_address);
                check_word($sformatf("write %0d data", write_count),
                           expected_store(write_count), data_writedata);
                mem[data_address[10:2]] = data_writedata;
                write_count++;
            end
        end
    end

    // 8 cycles of reset, active must stay low throughout
    task automatic apply_reset();
        int i;
        @(posedge clk);
        #1;
        rst_n       = 1'b0;
        read_count  = 0;
        write_count = 0;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            check_bit("active during reset", 1'b0, active);
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_active(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (active !== level) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout after %0d cycles waiting for %s", limit, what));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_for_writes(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (write_count < target) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout waiting for %0d data writes", target));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // one full program run from reset release to halt
    task automatic run_to_halt(input string name);
        int i;
        wait_for_active(1'b1, 4, "active to rise after reset");
        wait_for_active(1'b0, 5000, "the core to halt");
        // halted core stays idle, the monitor flags any strobe
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_bit({name, " active after halt"}, 1'b0, active);
        end
        check_word({name, " read count"}, series_count, 32'(read_count));
        check_word({name, " write count"}, series_count, 32'(write_count));
    endtask

    initial begin
        logic [9:0] w;
        rst_n       = 1'b0;
        read_count  = 0;
        write_count = 0;
        seed        = 32'h0ee8_6974;
        seed_value  = $random(seed);
        step        = $random(seed);
        // arithmetic series over the whole memory
        for (w = 10'd0; w < 10'(mem_words); w++) begin
            mem[w[8:0]] = seed_value + step * 32'(w);
        end

        apply_reset();
        run_to_halt("first run");

        // restart, then cut the run short partway through the stores
        apply_reset();
        wait_for_active(1'b1, 4, "active to rise after reset");
        wait_for_writes(int'(series_count) / 2, 2000);
        apply_reset();
        run_to_halt("rerun after mid-run reset");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verilog/mips_cpu_top.sv
`timescale 1ns/1ps

module mips_cpu_top #(
    parameter int unsigned series_count = 30,
    parameter int unsigned store_base   = 32'h480,
    parameter int unsigned rom_words    = 4096
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t data_address,
    output logic            data_read,
    output logic            data_write,
    output mips_pkg::word_t data_writedata,
    input  mips_pkg::word_t data_readdata
);

    // fetch side
    mips_pkg::word_t       instr_address;
    mips_pkg::word_t       instr_readdata;
    logic                  fetch_valid;
    mips_pkg::word_t       fetch_instr;
    logic                  stall;
    logic                  jump;
    mips_pkg::word_t       jump_target;
    logic                  pipe_empty;

    // decode to execute
    logic                  dec_valid;
    mips_pkg::instr_kind_t dec_kind;
    mips_pkg::reg_idx_t    dec_dest;
    mips_pkg::word_t       dec_rs_value;
    mips_pkg::word_t       dec_rt_value;
    mips_pkg::word_t       dec_imm;

    // execute to memory, plus scoreboard and write-back returns
    logic                  ex_valid;
    mips_pkg::instr_kind_t ex_kind;
    mips_pkg::reg_idx_t    ex_dest;
    logic                  ex_pending;
    mips_pkg::word_t       ex_result;
    mips_pkg::word_t       ex_store_data;
    mips_pkg::reg_idx_t    mem_dest;
    logic                  mem_pending;
    logic                  wb_enable;
    mips_pkg::reg_idx_t    wb_index;
    mips_pkg::word_t       wb_data;

    test_program_rom #(
        .series_count (series_count),
        .store_base   (store_base),
        .rom_words    (rom_words)
    ) u_rom (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    fetch_stage u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .jump           (jump),
        .jump_target    (jump_target),
        .instr_readdata (instr_readdata),
        .pipe_empty     (pipe_empty),
        .instr_address  (instr_address),
        .fetch_valid    (fetch_valid),
        .fetch_instr    (fetch_instr),
        .active         (active)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .ex_dest      (ex_dest),
        .ex_pending   (ex_pending),
        .mem_dest     (mem_dest),
        .mem_pending  (mem_pending),
        .wb_enable    (wb_enable),
        .wb_index     (wb_index),
        .wb_data      (wb_data),
        .squash       (jump),
        .stall        (stall),
        .dec_valid    (dec_valid),
        .dec_kind     (dec_kind),
        .dec_dest     (dec_dest),
        .dec_rs_value (dec_rs_value),
        .dec_rt_value (dec_rt_value),
        .dec_imm      (dec_imm)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_kind      (dec_kind),
        .dec_dest      (dec_dest),
        .dec_rs_value  (dec_rs_value),
        .dec_rt_value  (dec_rt_value),
        .dec_imm       (dec_imm),
        .ex_valid      (ex_valid),
        .ex_kind       (ex_kind),
        .ex_dest       (ex_dest),
        .ex_pending    (ex_pending),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .jump          (jump),
        .jump_target   (jump_target)
    );

    memory_writeback_stage u_memwb (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid       (ex_valid),
        .ex_kind        (ex_kind),
        .ex_dest        (ex_dest),
        .ex_result      (ex_result),
        .ex_store_data  (ex_store_data),
        .data_readdata  (data_readdata),
        .mem_dest       (mem_dest),
        .mem_pending    (mem_pending),
        .data_address   (data_address),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .wb_enable      (wb_enable),
        .wb_index       (wb_index),
        .wb_data        (wb_data),
        .pipe_empty     (pipe_empty)
    );

endmodule

// File: verilog/memory_writeback_stage.sv
`timescale 1ns/1ps

module memory_writeback_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  mips_pkg::instr_kind_t ex_kind,
    input  mips_pkg::reg_idx_t    ex_dest,
    input  mips_pkg::word_t       ex_result,
    input  mips_pkg::word_t       ex_store_data,
    input  mips_pkg::word_t       data_readdata,
    output mips_pkg::reg_idx_t    mem_dest,
    output logic                  mem_pending,
    output mips_pkg::word_t       data_address,
    output logic                  data_read,
    output logic                  data_write,
    output mips_pkg::word_t       data_writedata,
    output logic                  wb_enable,
    output mips_pkg::reg_idx_t    wb_index,
    output mips_pkg::word_t       wb_data,
    output logic                  pipe_empty
);

    logic                  mem_valid;
    mips_pkg::instr_kind_t mem_kind;
    mips_pkg::word_t       mem_result;
    mips_pkg::word_t       mem_store_data;
    logic                  is_lw;
    logic                  is_sw;
    logic                  is_addiu;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_kind  <= mips_pkg::kind_nop;
        end else begin
            mem_valid <= ex_valid;
            mem_kind  <= ex_valid ? ex_kind : mips_pkg::kind_nop;
        end
    end

    always_ff @(posedge clk) begin
        mem_dest       <= ex_dest;
        mem_result     <= ex_result;
        mem_store_data <= ex_store_data;
    end

    assign is_lw    = mem_valid && mem_kind == mips_pkg::kind_lw;
    assign is_sw    = mem_valid && mem_kind == mips_pkg::kind_sw;
    assign is_addiu = mem_valid && mem_kind == mips_pkg::kind_addiu;

    // each instruction spends one cycle here so the strobes last one cycle
    assign data_read      = is_lw;
    assign data_write     = is_sw;
    assign data_address   = mem_result;
    assign data_writedata = mem_store_data;

    // memory answers in the same cycle so load data goes straight to the regfile
    assign wb_enable = (is_lw || is_addiu) && mem_dest != '0;
    assign wb_index  = mem_dest;
    assign wb_data   = is_lw ? data_readdata : mem_result;

    // scoreboard entry for decode
    assign mem_pending = wb_enable;

    // nothing left below decode that could still write or touch memory
    assign pipe_empty = !mem_valid && !ex_valid;

    // the data bus has no byte enables so every access is a whole word
    assert property (@(posedge clk) disable iff (!rst_n)
                     (data_read || data_write) |-> data_address[1:0] == 2'b00)
    else $error("misaligned data access at %h", data_address);

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dec_valid,
    input  mips_pkg::instr_kind_t dec_kind,
    input  mips_pkg::reg_idx_t    dec_dest,
    input  mips_pkg::word_t       dec_rs_value,
    input  mips_pkg::word_t       dec_rt_value,
    input  mips_pkg::word_t       dec_imm,
    output logic                  ex_valid,
    output mips_pkg::instr_kind_t ex_kind,
    output mips_pkg::reg_idx_t    ex_dest,
    output logic                  ex_pending,
    output mips_pkg::word_t       ex_result,
    output mips_pkg::word_t       ex_store_data,
    output logic                  jump,
    output mips_pkg::word_t       jump_target
);

    logic is_jr;

    assign is_jr = dec_valid && dec_kind == mips_pkg::kind_jr;

    // jr resolves here, fetch sees it while the jr sits in this stage
    assign jump        = is_jr;
    assign jump_target = dec_rs_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_kind  <= mips_pkg::kind_nop;
        end else if (dec_valid && !is_jr) begin
            ex_valid <= 1'b1;
            ex_kind  <= dec_kind;
        end else begin
            // jr has nothing left to do below, it leaves as a bubble
            ex_valid <= 1'b0;
            ex_kind  <= mips_pkg::kind_nop;
        end
    end

    // same adder gives the lw/sw address and the addiu sum
    always_ff @(posedge clk) begin
        ex_dest       <= dec_dest;
        ex_result     <= dec_rs_value + dec_imm;
        ex_store_data <= dec_rt_value;
    end

    // destination index is zero for sw and jr
    assign ex_pending = ex_valid && ex_dest != '0;

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  mips_pkg::word_t       fetch_instr,
    input  mips_pkg::reg_idx_t    ex_dest,
    input  logic                  ex_pending,
    input  mips_pkg::reg_idx_t    mem_dest,
    input  logic                  mem_pending,
    input  logic                  wb_enable,
    input  mips_pkg::reg_idx_t    wb_index,
    input  mips_pkg::word_t       wb_data,
    input  logic                  squash,
    output logic                  stall,
    output logic                  dec_valid,
    output mips_pkg::instr_kind_t dec_kind,
    output mips_pkg::reg_idx_t    dec_dest,
    output mips_pkg::word_t       dec_rs_value,
    output mips_pkg::word_t       dec_rt_value,
    output mips_pkg::word_t       dec_imm
);

    mips_pkg::word_t       regs [0:31];
    mips_pkg::reg_idx_t    rs_idx;
    mips_pkg::reg_idx_t    rt_idx;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    mips_pkg::instr_kind_t kind;
    logic                  known_op;
    mips_pkg::reg_idx_t    dest;
    mips_pkg::word_t       rs_value;
    mips_pkg::word_t       rt_value;
    logic                  rt_used;
    logic                  dec_pending;
    logic                  rs_hazard;
    logic                  rt_hazard;

    // field split
    assign opcode = fetch_instr[31:26];
    assign rs_idx = fetch_instr[25:21];
    assign rt_idx = fetch_instr[20:16];
    assign funct  = fetch_instr[5:0];

    always_comb begin
        kind     = mips_pkg::kind_nop;
        known_op = 1'b1;
        case (opcode)
            mips_pkg::op_lw:    kind = mips_pkg::kind_lw;
            mips_pkg::op_sw:    kind = mips_pkg::kind_sw;
            mips_pkg::op_addiu: kind = mips_pkg::kind_addiu;
            // other r-type words, like the all-zero word, act as nop
            mips_pkg::op_special: begin
                if (funct == mips_pkg::funct_jr) begin
                    kind = mips_pkg::kind_jr;
                end
            end
            default: known_op = 1'b0;
        endcase
    end

    // only lw and addiu write, their target is rt
    assign dest = (kind == mips_pkg::kind_lw || kind == mips_pkg::kind_addiu) ? rt_idx : '0;
    // sw is the only reader of rt
    assign rt_used = (kind == mips_pkg::kind_sw);

    // r0 reads as zero, a write in this cycle shows through
    assign rs_value = (rs_idx == '0) ? '0 :
                      (wb_enable && wb_index == rs_idx) ? wb_data : regs[rs_idx];
    assign rt_value = (rt_idx == '0) ? '0 :
                      (wb_enable && wb_index == rt_idx) ? wb_data : regs[rt_idx];

    // scoreboard: destinations still in flight below decode
    assign dec_pending = dec_valid && dec_dest != '0;
    assign rs_hazard = (rs_idx != '0) &&
                       ((dec_pending && dec_dest == rs_idx) ||
                        (ex_pending && ex_dest == rs_idx) ||
                        (mem_pending && mem_dest == rs_idx));
    assign rt_hazard = rt_used && (rt_idx != '0) &&
                       ((dec_pending && dec_dest == rt_idx) ||
                        (ex_pending && ex_dest == rt_idx) ||
                        (mem_pending && mem_dest == rt_idx));
    // a squashed word never stalls
    assign stall = fetch_valid && !squash && (rs_hazard || rt_hazard);

    always_ff @(posedge clk) begin
        if (wb_enable) begin
            regs[wb_index] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_kind  <= mips_pkg::kind_nop;
        end else if (fetch_valid && !squash && !stall) begin
            dec_valid <= 1'b1;
            dec_kind  <= kind;
        end else begin
            // bubble
            dec_valid <= 1'b0;
            dec_kind  <= mips_pkg::kind_nop;
        end
    end

    always_ff @(posedge clk) begin
        dec_dest     <= dest;
        dec_rs_value <= rs_value;
        dec_rt_value <= rt_value;
        dec_imm      <= {{16{fetch_instr[15]}}, fetch_instr[15:0]};
    end

    // every word fetch hands over for real must be one this core knows
    assert property (@(posedge clk) disable iff (!rst_n) fetch_valid && !squash |-> known_op)
    else $error("unknown opcode %b", opcode);

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            jump,
    input  mips_pkg::word_t jump_target,
    input  mips_pkg::word_t instr_readdata,
    input  logic            pipe_empty,
    output mips_pkg::word_t instr_address,
    output logic            fetch_valid,
    output mips_pkg::word_t fetch_instr,
    output logic            active
);

    mips_pkg::word_t pc;
    // set once the core jumps back to address 0
    logic            halted;

    assign instr_address = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= 32'd4;
            halted      <= 1'b0;
            fetch_valid <= 1'b0;
            active      <= 1'b0;
        end else begin
            // stays high until the halt has drained the pipe
            active <= !(halted && pipe_empty);
            if (jump) begin
                // redirect and drop the word fetched behind the jr
                pc          <= jump_target;
                halted      <= (jump_target == '0);
                fetch_valid <= 1'b0;
            end else if (!stall) begin
                fetch_valid <= !halted;
                if (!halted) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // instruction word follows the valid level and holds during a stall
    always_ff @(posedge clk) begin
        if (!jump && !stall && !halted) begin
            fetch_instr <= instr_readdata;
        end
    end

    // the jr that halts the core is the last one to reach execute
    assert property (@(posedge clk) disable iff (!rst_n) jump |-> !halted)
    else $error("jump arrived after fetch halted");

endmodule

// File: verilog/test_program_rom.sv
`timescale 1ns/1ps

module test_program_rom #(
    parameter int unsigned series_count = 30,
    parameter int unsigned store_base   = 32'h480,
    parameter int unsigned rom_words    = 4096
) (
    input  mips_pkg::word_t instr_address,
    output mips_pkg::word_t instr_readdata
);

    localparam int addr_bits = $clog2(rom_words);

    mips_pkg::word_t rom [0:rom_words-1];

    // i-type layout: opcode, rs, rt, 16-bit immediate
    function automatic mips_pkg::word_t i_type(
        input logic [5:0]         opcode,
        input mips_pkg::reg_idx_t rs,
        input mips_pkg::reg_idx_t rt,
        input logic [15:0]        imm
    );
        return {opcode, rs, rt, imm};
    endfunction

    initial begin
        int w;
        int k;
        // clear everything, word 0 stays a nop and is the halt target
        for (w = 0; w < int'(rom_words); w++) begin
            rom[w] = '0;
        end
        // program starts at byte address 4
        w = 1;
        // lw ri, 4*(i-2)(r0) pulls the series into r2..r31
        for (k = 0; k < int'(series_count); k++) begin
            rom[w] = i_type(mips_pkg::op_lw, 5'd0, 5'(k + 2), 16'(4 * k));
            w++;
        end
        // addiu ri, ri, low16(0x1111*(i-2))
        // the immediate wraps past 16 bits for the upper registers
        for (k = 0; k < int'(series_count); k++) begin
            rom[w] = i_type(mips_pkg::op_addiu, 5'(k + 2), 5'(k + 2),
                            16'(32'h1111 * k));
            w++;
        end
        // sw ri, store_base+4*(i-2)(r0)
        for (k = 0; k < int'(series_count); k++) begin
            rom[w] = i_type(mips_pkg::op_sw, 5'd0, 5'(k + 2),
                            16'(store_base + 4 * k));
            w++;
        end
        // jr r0 sends the core back to address 0, which halts it
        rom[w] = {mips_pkg::op_special, 5'd0, 15'd0, mips_pkg::funct_jr};
    end

    // byte address in, word index out
    assign instr_readdata = rom[instr_address[addr_bits+1:2]];

    // the pc must stay word aligned and inside the array
    always_comb begin
        if (!$isunknown(instr_address)) begin
            assert (instr_address[1:0] == 2'b00 && instr_address < rom_words * 4)
            else $error("instruction fetch outside rom or misaligned: %h", instr_address);
        end
    end

endmodule

// File: verilog/mips_pkg.sv
package mips_pkg;

    // one machine word, used for instructions, addresses and data
    typedef logic [31:0] word_t;

    // index into the 32-entry register file
    typedef logic [4:0] reg_idx_t;

    // primary opcodes, bits 31:26 of the instruction word
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;
    localparam logic [5:0] op_addiu   = 6'b001001;
    // r-type group, the operation sits in the funct field
    localparam logic [5:0] op_special = 6'b000000;

    // funct field, bits 5:0, of the r-type group
    localparam logic [5:0] funct_jr = 6'b001000;

    // decoded instruction class carried down the pipe
    // kind_nop also marks a bubble
    typedef enum logic [2:0] {
        kind_nop,
        kind_lw,
        kind_sw,
        kind_addiu,
        kind_jr
    } instr_kind_t;

endpackage
